/* vec_geom_pkg.sv */
/*
    Vector unit geometry shared by the lane driver and its datapath units.
    Holds the lane count, register-file sizes and derived widths.
*/

`default_nettype none

package vec_geom_pkg;

    //////////////////////////////////////////////////////////////////////
    // Lanes and register file
    localparam int VLANE_NUM       = 8;                     // One word per lane per cycle
    localparam int LANE_W          = $clog2(VLANE_NUM);
    localparam int MEM_DEPTH       = 512;                   // Words per lane
    localparam int ADDR_W          = $clog2(MEM_DEPTH);
    localparam int BYTES_PER_WORD  = 4;
    localparam int RD_PORTS        = 3;                     // vs1, vs2, vs3

    //////////////////////////////////////////////////////////////////////
    // Vector length
    localparam int MAX_VL_PER_LANE = 256;
    localparam int VL_W            = $clog2(VLANE_NUM * MAX_VL_PER_LANE);

    // Cycle and mask counters, one spare bit so the full count fits
    localparam int CNT_W           = $clog2(MAX_VL_PER_LANE) + 1;

    // Element width, same coding as the low bits of vsew
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } elem_width_e;

endpackage

`default_nettype wire

/* vec_ctrl_pkg.sv */
/*
    Instruction control types for the lane sequencer.
*/

`default_nettype none

package vec_ctrl_pkg;

    // Codes 1, 6 and 7 are reserved
    typedef enum logic [2:0] {
        INST_NORMAL        = 3'd0,
        INST_STORE         = 3'd2,
        INST_INDEXED_STORE = 3'd3,
        INST_LOAD          = 3'd4,
        INST_INDEXED_LOAD  = 3'd5
    } inst_type_e;

    typedef enum logic [1:0] {
        IDLE,
        NORMAL_MODE,        // Reads, then delayed writes
        READ_MODE,          // Stores and indexed load
        LOAD_MODE           // Writes paced by load beats
    } seq_state_e;

    // Write delay is counted on the main cycle counter
    localparam int INST_DELAY_W = vec_geom_pkg::CNT_W;

endpackage

`default_nettype wire

/* vrf_addr_counter.sv */
/*
    Register-file address counter. Loaded with a start row, it steps one
    row after every 4, 2 or 1 elements depending on the element width.
*/

`timescale 1ns/1ps
`default_nettype none

module vrf_addr_counter (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            load_i,
    input  logic                            en_i,
    input  logic [vec_geom_pkg::ADDR_W-1:0] start_i,
    input  vec_geom_pkg::elem_width_e       width_i,
    output logic [vec_geom_pkg::ADDR_W-1:0] addr_o
);

    import vec_geom_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        sub_q;               // Element within the current word
    elem_width_e       width_q;             // Captured with the start row
    logic              wrap;

    always_comb begin
        case (width_q)
            EW8:     wrap = (sub_q == 2'd3);
            EW16:    wrap = sub_q[0];
            default: wrap = 1'b1;           // Word elements step every time
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q  <= '0;
            sub_q   <= '0;
            width_q <= EW32;
        end else if (load_i) begin
            addr_q  <= start_i;
            sub_q   <= '0;
            width_q <= width_i;
        end else if (en_i) begin
            if (wrap) begin
                addr_q <= addr_q + 1'b1;
                sub_q  <= '0;
            end else begin
                sub_q  <= sub_q + 1'b1;
            end
        end
    end

    assign addr_o = addr_q;

endmodule

`default_nettype wire

/* byte_enable_gen.sv */
/*
    Byte write enable pattern for one word. A one-hot phase walks the
    bytes of the word, decoded per element width.
*/

`timescale 1ns/1ps
`default_nettype none

module byte_enable_gen (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    load_i,
    input  logic                                    en_i,
    input  vec_geom_pkg::elem_width_e               width_i,
    output logic [vec_geom_pkg::BYTES_PER_WORD-1:0] bwen_o
);

    import vec_geom_pkg::*;

    logic [BYTES_PER_WORD-1:0] phase_q;     // One-hot, byte of the next element
    elem_width_e               width_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            phase_q <= 4'b0001;
            width_q <= EW32;
        end else if (load_i) begin
            phase_q <= 4'b0001;
            width_q <= width_i;
        end else if (en_i) begin
            phase_q <= {phase_q[2:0], phase_q[3]};
        end
    end

    always_comb begin
        bwen_o = '0;
        if (en_i) begin
            case (width_q)
                EW8:     bwen_o = phase_q;
                EW16:    bwen_o = {{2{phase_q[1] | phase_q[3]}}, {2{phase_q[0] | phase_q[2]}}};
                default: bwen_o = 4'b1111;
            endcase
        end
    end

endmodule

`default_nettype wire

/* lane_valid_mask.sv */
/*
    Per-lane read data valid mask. Tracks how many elements remain and
    marks the lanes that still hold one in the current row.
*/

`timescale 1ns/1ps
`default_nettype none

module lane_valid_mask (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               load_i,
    input  logic                               shift_i,
    input  logic [vec_geom_pkg::VL_W-1:0]      vl_i,
    input  logic                               valid_i,
    output logic [vec_geom_pkg::VLANE_NUM-1:0] valid_o
);

    import vec_geom_pkg::*;

    logic [VL_W-1:0] rem_q;                 // Elements not yet read

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rem_q <= '0;
        end else if (load_i) begin
            rem_q <= vl_i;
        end else if (shift_i) begin
            rem_q <= (rem_q > VL_W'(VLANE_NUM)) ? rem_q - VL_W'(VLANE_NUM) : '0;
        end
    end

    // Thermometer, low lanes fill first
    always_comb begin
        for (int l = 0; l < VLANE_NUM; l++) begin
            valid_o[l] = valid_i && (rem_q > VL_W'(l));
        end
    end

endmodule

`default_nettype wire

/* sublane_sequencer.sv */
/*
    Control FSM of the lane driver. Accepts an instruction, counts mode
    cycles and tells the address, byte-enable and mask units when to step.
*/

`timescale 1ns/1ps
`default_nettype none

module sublane_sequencer (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  start_valid_i,
    input  vec_ctrl_pkg::inst_type_e              inst_type_i,
    input  logic [vec_geom_pkg::VL_W-1:0]         vl_i,
    input  logic [vec_ctrl_pkg::INST_DELAY_W-1:0] inst_delay_i,
    input  logic                                  load_valid_i,
    input  logic                                  load_last_i,
    output logic                                  ready_o,
    output logic                                  ready_for_load_o,
    output logic                                  rd_load_o,
    output logic                                  rd_en_o,
    output logic                                  wr_load_o,
    output logic                                  wr_en_o,
    output logic                                  load_phase_o,
    output logic                                  mask_load_o,
    output logic                                  mask_shift_o,
    output logic                                  store_data_valid_o,
    output logic                                  store_load_index_valid_o,
    output logic [vec_geom_pkg::CNT_W-1:0]        vmrf_addr_o,
    output logic                                  vmrf_wen_o
);

    import vec_geom_pkg::*;
    import vec_ctrl_pkg::*;

    seq_state_e              state_q, state_d;
    inst_type_e              type_q;
    logic [CNT_W-1:0]        rlim_q;            // Reads per lane, ceil(vl / lanes)
    logic [CNT_W-1:0]        rlim_d;
    logic [INST_DELAY_W-1:0] delay_q;
    logic [CNT_W-1:0]        cnt_q;             // Mode cycle
    logic [CNT_W-1:0]        mcnt_q;            // Write index
    logic                    rfl_q;
    logic                    accept;
    logic                    rd_active;
    logic                    wr_normal;
    logic                    beat;
    logic                    cnt_en;
    logic                    is_store;
    logic                    is_index;

    assign accept = start_valid_i && ready_o;
    assign rlim_d = CNT_W'(vl_i >> LANE_W) + CNT_W'(|vl_i[LANE_W-1:0]);

    //////////////////////////////////////////////////////////////////////
    // Cycle decode
    assign rd_active = ((state_q == NORMAL_MODE) || (state_q == READ_MODE)) && (cnt_q < rlim_q);
    assign wr_normal = (state_q == NORMAL_MODE) && (cnt_q >= delay_q) && (mcnt_q < rlim_q);
    assign beat      = (state_q == LOAD_MODE) && rfl_q && load_valid_i;

    // Counter parks at max(R, D) so it never wraps
    assign cnt_en = (state_q == READ_MODE) ||
                    ((state_q == NORMAL_MODE) && ((cnt_q < rlim_q) || (cnt_q < delay_q)));

    assign is_store = (type_q == INST_STORE) || (type_q == INST_INDEXED_STORE);
    assign is_index = (type_q == INST_INDEXED_STORE) || (type_q == INST_INDEXED_LOAD);

    assign ready_o          = (state_q == IDLE);
    assign ready_for_load_o = rfl_q;
    assign rd_load_o        = accept;
    assign wr_load_o        = accept;
    assign mask_load_o      = accept;
    assign rd_en_o          = rd_active;
    assign mask_shift_o     = rd_active;
    assign wr_en_o          = wr_normal || beat;
    assign load_phase_o     = beat;
    assign vmrf_wen_o       = wr_normal;
    assign vmrf_addr_o      = mcnt_q;

    assign store_data_valid_o       = rd_active && (state_q == READ_MODE) && is_store;
    assign store_load_index_valid_o = rd_active && (state_q == READ_MODE) && is_index;

    //////////////////////////////////////////////////////////////////////
    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    case (inst_type_i)
                        INST_NORMAL:        state_d = NORMAL_MODE;
                        INST_STORE,
                        INST_INDEXED_STORE,
                        INST_INDEXED_LOAD:  state_d = READ_MODE;
                        INST_LOAD:          state_d = LOAD_MODE;
                        default:            state_d = IDLE;
                    endcase
                end
            end
            NORMAL_MODE: begin
                if (mcnt_q == rlim_q) state_d = IDLE;   // One idle cycle after last write
            end
            READ_MODE: begin
                if (cnt_q == rlim_q - 1'b1) state_d = IDLE;
            end
            LOAD_MODE: begin
                if (beat && load_last_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            mcnt_q  <= '0;
            rfl_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // Opens one cycle into load mode, drops after the last beat
            rfl_q   <= (state_q == LOAD_MODE) && !(beat && load_last_i);
            if (accept) begin
                cnt_q  <= '0;
                mcnt_q <= '0;
            end else begin
                if (cnt_en) cnt_q <= cnt_q + 1'b1;
                if (wr_en_o) mcnt_q <= mcnt_q + 1'b1;
            end
        end
    end

    // Instruction fields held for the whole instruction
    always_ff @(posedge clk_i) begin
        if (accept) begin
            type_q  <= inst_type_i;
            rlim_q  <= rlim_d;
            delay_q <= inst_delay_i;
        end
    end

endmodule

`default_nettype wire

/* sublane_driver.sv */
/*
    Per-lane sequencing driver of the vector unit. Accepts one instruction
    at a time and walks the register file for it, read and write side.
*/

`timescale 1ns/1ps
`default_nettype none

module sublane_driver (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    input  logic                                                  start_valid_i,
    input  vec_ctrl_pkg::inst_type_e                              inst_type_i,
    input  logic [vec_geom_pkg::VL_W-1:0]                         vl_i,
    input  vec_geom_pkg::elem_width_e                             sew_i,
    input  logic [vec_ctrl_pkg::INST_DELAY_W-1:0]                 inst_delay_i,
    input  logic [vec_geom_pkg::ADDR_W-1:0]                       waddr_start_i,
    input  logic [vec_geom_pkg::RD_PORTS-1:0][vec_geom_pkg::ADDR_W-1:0] raddr_start_i,
    input  logic                                                  load_valid_i,
    input  logic                                                  load_last_i,
    input  logic [vec_geom_pkg::VLANE_NUM-1:0][vec_geom_pkg::BYTES_PER_WORD-1:0] load_bwen_i,
    output logic                                                  ready_o,
    output logic                                                  ready_for_load_o,
    output logic                                                  vrf_ren_o,
    output logic [vec_geom_pkg::RD_PORTS-1:0][vec_geom_pkg::ADDR_W-1:0] vrf_raddr_o,
    output logic [vec_geom_pkg::VLANE_NUM-1:0][vec_geom_pkg::ADDR_W-1:0] vrf_waddr_o,
    output logic [vec_geom_pkg::VLANE_NUM-1:0][vec_geom_pkg::BYTES_PER_WORD-1:0] vrf_bwen_o,
    output logic [vec_geom_pkg::VLANE_NUM-1:0]                    read_data_valid_o,
    output logic                                                  store_data_valid_o,
    output logic                                                  store_load_index_valid_o,
    output logic [vec_geom_pkg::CNT_W-1:0]                        vmrf_addr_o,
    output logic                                                  vmrf_wen_o
);

    import vec_geom_pkg::*;
    import vec_ctrl_pkg::*;

    logic                      rd_load;
    logic                      rd_en;
    logic                      wr_load;
    logic                      wr_en;
    logic                      load_phase;          // Accepted load beat this cycle
    logic                      mask_load;
    logic                      mask_shift;
    logic [ADDR_W-1:0]         waddr;
    logic [BYTES_PER_WORD-1:0] gen_bwen;
    elem_width_e               wr_width;

    // Load beats are whole words, one address step per beat
    assign wr_width  = (inst_type_i == INST_LOAD) ? EW32 : sew_i;
    assign vrf_ren_o = rd_en;

    //////////////////////////////////////////////////////////////////////
    // Control
    sublane_sequencer u_seq (
        .clk_i                    (clk_i),
        .rst_i                    (rst_i),
        .start_valid_i            (start_valid_i),
        .inst_type_i              (inst_type_i),
        .vl_i                     (vl_i),
        .inst_delay_i             (inst_delay_i),
        .load_valid_i             (load_valid_i),
        .load_last_i              (load_last_i),
        .ready_o                  (ready_o),
        .ready_for_load_o         (ready_for_load_o),
        .rd_load_o                (rd_load),
        .rd_en_o                  (rd_en),
        .wr_load_o                (wr_load),
        .wr_en_o                  (wr_en),
        .load_phase_o             (load_phase),
        .mask_load_o              (mask_load),
        .mask_shift_o             (mask_shift),
        .store_data_valid_o       (store_data_valid_o),
        .store_load_index_valid_o (store_load_index_valid_o),
        .vmrf_addr_o              (vmrf_addr_o),
        .vmrf_wen_o               (vmrf_wen_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Address generation
    vrf_addr_counter u_waddr (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .load_i  (wr_load),
        .en_i    (wr_en),
        .start_i (waddr_start_i),
        .width_i (wr_width),
        .addr_o  (waddr)
    );

    for (genvar p = 0; p < RD_PORTS; p++) begin : g_raddr
        vrf_addr_counter u_raddr (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .load_i  (rd_load),
            .en_i    (rd_en),
            .start_i (raddr_start_i[p]),
            .width_i (sew_i),
            .addr_o  (vrf_raddr_o[p])
        );
    end

    assign vrf_waddr_o = {VLANE_NUM{waddr}};   // Same row in every lane

    //////////////////////////////////////////////////////////////////////
    // Byte enables and read valid mask
    byte_enable_gen u_bwen (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .load_i  (wr_load),
        .en_i    (wr_en),
        .width_i (sew_i),
        .bwen_o  (gen_bwen)
    );

    for (genvar l = 0; l < VLANE_NUM; l++) begin : g_bwen
        assign vrf_bwen_o[l] = load_phase ? load_bwen_i[l] : gen_bwen;
    end

    lane_valid_mask u_mask (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .load_i  (mask_load),
        .shift_i (mask_shift),
        .vl_i    (vl_i),
        .valid_i (rd_en),
        .valid_o (read_data_valid_o)
    );

endmodule

`default_nettype wire

/* tb_sublane_driver.sv */
/*
    Random-stimulus testbench for the lane driver. Each instruction is checked
    cycle by cycle against a reference model built from the address rules.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_sublane_driver;

    import vec_geom_pkg::*;
    import vec_ctrl_pkg::*;

    localparam logic [31:0] SEED = 32'h85043de8;
    localparam int NUM_TESTS   = 40;
    localparam int MAX_R       = 32;                // Rows per instruction and max load beats
    localparam int MAX_D       = 15;
    localparam int DRV         = 1;                 // Input skew after the rising edge
    localparam int TEST_CYCLES = MAX_D + 4 * MAX_R + 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + 16;

    logic                                         clk_i;
    logic                                         rst_i;
    logic                                         start_valid_i;
    inst_type_e                                   inst_type_i;
    logic [VL_W-1:0]                              vl_i;
    elem_width_e                                  sew_i;
    logic [INST_DELAY_W-1:0]                      inst_delay_i;
    logic [ADDR_W-1:0]                            waddr_start_i;
    logic [RD_PORTS-1:0][ADDR_W-1:0]              raddr_start_i;
    logic                                         load_valid_i;
    logic                                         load_last_i;
    logic [VLANE_NUM-1:0][BYTES_PER_WORD-1:0]     load_bwen_i;
    logic                                         ready_o;
    logic                                         ready_for_load_o;
    logic                                         vrf_ren_o;
    logic [RD_PORTS-1:0][ADDR_W-1:0]              vrf_raddr_o;
    logic [VLANE_NUM-1:0][ADDR_W-1:0]             vrf_waddr_o;
    logic [VLANE_NUM-1:0][BYTES_PER_WORD-1:0]     vrf_bwen_o;
    logic [VLANE_NUM-1:0]                         read_data_valid_o;
    logic                                         store_data_valid_o;
    logic                                         store_load_index_valid_o;
    logic [CNT_W-1:0]                             vmrf_addr_o;
    logic                                         vmrf_wen_o;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycle_cnt;
    int          t;

    sublane_driver uut (.*);

    //////////////////////////////////////////////////////////////////////
    // Clock and run limit
    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run was still busy after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng = x;
        return x;
    endfunction

    // Byte lanes written by element k of a word stream
    function automatic logic [BYTES_PER_WORD-1:0] expected_bwen(elem_width_e w, int k);
        case (w)
            EW8:     return 4'b0001 << (k % 4);
            EW16:    return (k % 2) ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bwen(input string name, input logic [BYTES_PER_WORD-1:0] got,
                              input logic [BYTES_PER_WORD-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input logic [VLANE_NUM-1:0] got,
                              input logic [VLANE_NUM-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_no_bwen();
        for (int l = 0; l < VLANE_NUM; l++)
            check_bwen($sformatf("vrf_bwen_o[%0d]", l), vrf_bwen_o[l], '0);
    endtask

    task automatic check_idle();
        check_flag("ready_o", ready_o, 1'b1);
        check_flag("ready_for_load_o", ready_for_load_o, 1'b0);
        check_flag("vrf_ren_o", vrf_ren_o, 1'b0);
        check_mask("read_data_valid_o", read_data_valid_o, '0);
        check_flag("store_data_valid_o", store_data_valid_o, 1'b0);
        check_flag("store_load_index_valid_o", store_load_index_valid_o, 1'b0);
        check_flag("vmrf_wen_o", vmrf_wen_o, 1'b0);
        check_no_bwen();
    endtask

    // Random beat stream with one gap in four
    task automatic drive_load(input inst_type_e typ, input int beats, input int nbeats);
        if (typ == INST_LOAD) begin
            load_valid_i = (next_rand() % 4) != 0;
            load_last_i  = (beats == nbeats - 1);
            load_bwen_i  = next_rand();
        end else begin
            load_valid_i = 1'b0;
            load_last_i  = 1'b0;
            load_bwen_i  = '0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Offers one instruction at the next edge and follows it to ready
    task automatic run_instruction(input int n);
        inst_type_e           typ;
        elem_width_e          sew;
        logic [31:0]          r;
        logic [VLANE_NUM-1:0] exp_mask;
        logic                 is_store;
        logic                 is_index;
        logic                 done;
        int vl, rlim, dly, s, nbeats, cyc, err_before;
        int rd_idx, wr_idx, beats, first_rd, first_wr;

        err_before = errors;
        r = next_rand();
        case (r % 5)
            0:       typ = INST_NORMAL;
            1:       typ = INST_STORE;
            2:       typ = INST_INDEXED_STORE;
            3:       typ = INST_INDEXED_LOAD;
            default: typ = INST_LOAD;
        endcase
        sew    = elem_width_e'(next_rand() % 3);
        vl     = next_rand() % (VLANE_NUM * MAX_R) + 1;
        dly    = next_rand() % (MAX_D + 1);
        nbeats = next_rand() % MAX_R + 1;
        rlim   = (vl + VLANE_NUM - 1) / VLANE_NUM;
        s      = (sew == EW8) ? 2 : (sew == EW16) ? 1 : 0;
        is_store = (typ == INST_STORE) || (typ == INST_INDEXED_STORE);
        is_index = (typ == INST_INDEXED_STORE) || (typ == INST_INDEXED_LOAD);
        rd_idx = 0;
        wr_idx = 0;
        beats  = 0;
        first_rd = -1;
        first_wr = -1;

        @(posedge clk_i);
        #DRV;
        start_valid_i = 1'b1;
        inst_type_i   = typ;
        sew_i         = sew;
        vl_i          = VL_W'(vl);
        inst_delay_i  = INST_DELAY_W'(dly);
        waddr_start_i = ADDR_W'(next_rand());
        for (int p = 0; p < RD_PORTS; p++)
            raddr_start_i[p] = ADDR_W'(next_rand());
        drive_load(INST_NORMAL, 0, 0);
        @(posedge clk_i);                           // Accepted here since ready was high
        #DRV;
        start_valid_i = 1'b0;
        drive_load(typ, beats, nbeats);

        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            if (ready_o) begin
                done = 1'b1;
            end else begin
                // Read side
                if (vrf_ren_o) begin
                    if (first_rd < 0) first_rd = cyc;
                    for (int p = 0; p < RD_PORTS; p++)
                        check_addr($sformatf("vrf_raddr_o[%0d]", p), vrf_raddr_o[p],
                                   ADDR_W'(raddr_start_i[p] + (rd_idx >> s)));
                    for (int l = 0; l < VLANE_NUM; l++)
                        exp_mask[l] = (rd_idx * VLANE_NUM + l) < vl;
                    check_mask("read_data_valid_o", read_data_valid_o, exp_mask);
                    rd_idx++;
                end else begin
                    check_mask("read_data_valid_o", read_data_valid_o, '0);
                end
                check_flag("store_data_valid_o", store_data_valid_o, vrf_ren_o && is_store);
                check_flag("store_load_index_valid_o", store_load_index_valid_o,
                           vrf_ren_o && is_index);

                // Write side
                if (typ == INST_LOAD) begin
                    check_flag("vrf_ren_o", vrf_ren_o, 1'b0);
                    check_flag("vmrf_wen_o", vmrf_wen_o, 1'b0);
                    if (ready_for_load_o && load_valid_i) begin
                        for (int l = 0; l < VLANE_NUM; l++) begin
                            check_addr($sformatf("vrf_waddr_o[%0d]", l), vrf_waddr_o[l],
                                       ADDR_W'(waddr_start_i + beats));
                            check_bwen($sformatf("vrf_bwen_o[%0d]", l), vrf_bwen_o[l],
                                       load_bwen_i[l]);
                        end
                        beats++;
                    end else begin
                        check_no_bwen();
                    end
                end else if (typ == INST_NORMAL && vmrf_wen_o) begin
                    if (first_wr < 0) first_wr = cyc;
                    for (int l = 0; l < VLANE_NUM; l++) begin
                        check_addr($sformatf("vrf_waddr_o[%0d]", l), vrf_waddr_o[l],
                                   ADDR_W'(waddr_start_i + (wr_idx >> s)));
                        check_bwen($sformatf("vrf_bwen_o[%0d]", l), vrf_bwen_o[l],
                                   expected_bwen(sew, wr_idx));
                    end
                    check_index("vmrf_addr_o", vmrf_addr_o, CNT_W'(wr_idx));
                    wr_idx++;
                end else begin
                    check_flag("vmrf_wen_o", vmrf_wen_o, 1'b0);
                    check_no_bwen();
                end
                if (typ != INST_LOAD)
                    check_flag("ready_for_load_o", ready_for_load_o, 1'b0);

                @(posedge clk_i);
                #DRV;
                drive_load(typ, beats, nbeats);
                cyc++;
            end
        end
        check_idle();

        // Totals for the whole instruction
        if (rd_idx != ((typ == INST_LOAD) ? 0 : rlim)) begin
            errors++;
            $display("Instruction %0d made %0d read cycles where %0d were due", n, rd_idx,
                     (typ == INST_LOAD) ? 0 : rlim);
        end
        if (typ == INST_NORMAL && wr_idx != rlim) begin
            errors++;
            $display("Instruction %0d made %0d writes where %0d were due", n, wr_idx, rlim);
        end
        if (typ == INST_NORMAL && first_rd >= 0 && first_wr >= 0 && first_wr - first_rd != dly) begin
            errors++;
            $display("Instruction %0d wrote %0d cycles after its first read instead of %0d",
                     n, first_wr - first_rd, dly);
        end
        if (typ == INST_LOAD && beats != nbeats) begin
            errors++;
            $display("Instruction %0d ended after %0d load beats where %0d were due",
                     n, beats, nbeats);
        end
        $display("test %0d %-18s vl=%0d sew=%s delay=%0d reads=%0d writes=%0d beats=%0d: %s",
                 n, typ.name(), vl, sew.name(), dly, rd_idx, wr_idx, beats,
                 (errors == err_before) ? "pass" : "fail");
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin
        rng           = SEED;
        errors        = 0;
        checks        = 0;
        cycle_cnt     = 0;
        rst_i         = 1'b0;
        start_valid_i = 1'b0;
        inst_type_i   = INST_NORMAL;
        vl_i          = '0;
        sew_i         = EW32;
        inst_delay_i  = '0;
        waddr_start_i = '0;
        raddr_start_i = '0;
        load_valid_i  = 1'b0;
        load_last_i   = 1'b0;
        load_bwen_i   = '0;

        repeat (2) @(posedge clk_i);
        #DRV;
        rst_i = 1'b1;
        @(negedge clk_i);
        check_idle();

        for (t = 0; t < NUM_TESTS; t++)
            run_instruction(t);

        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
vec_geom_pkg.sv
vec_ctrl_pkg.sv
vrf_addr_counter.sv
byte_enable_gen.sv
lane_valid_mask.sv
sublane_sequencer.sv
sublane_driver.sv
tb_sublane_driver.sv

/* Bender.yml */
package:
  name: sublane_driver

sources:
  - files:
      - vec_geom_pkg.sv
      - vec_ctrl_pkg.sv
      - vrf_addr_counter.sv
      - byte_enable_gen.sv
      - lane_valid_mask.sv
      - sublane_sequencer.sv
      - sublane_driver.sv
  - target: simulation
    files:
      - tb_sublane_driver.sv
